// File: source/isaPkg.sv
// --------------------
// Instruction set of the vector core slice.
// Opcodes and the two views of an instruction word.
// --------------------
`default_nettype none

package isaPkg;

	localparam int regFieldW = 4;
	localparam int immW = 14;
	localparam int offsetW = 28;

	typedef enum logic [3:0] {
		opAdd  = 4'd0,
		opSub  = 4'd1,
		opAnd  = 4'd2,
		opOrr  = 4'd3,
		opVadd = 4'd4,   // Vector ops work lane by lane.
		opVsub = 4'd5,
		opVand = 4'd6,
		opVorr = 4'd7,
		opStr  = 4'd8,   // Address rn + imm, data rm.
		opB    = 4'd9,
		opNop  = 4'd10
	} opcodeT;

	// Data-processing view, also used by vector ops and stores.
	typedef struct packed {
		opcodeT opcode;
		logic immSel;                  // Second operand from imm.
		logic setFlags;
		logic [regFieldW-1:0] rd;
		logic [regFieldW-1:0] rn;
		logic [regFieldW-1:0] rm;
		logic [immW-1:0] imm;          // Zero extended.
	} dpFormT;

	// Branch view.
	typedef struct packed {
		opcodeT opcode;
		logic signed [offsetW-1:0] offset;
	} brFormT;

	// Both views keep the opcode in the top nibble.
	typedef union packed {
		dpFormT dp;
		brFormT br;
	} instrWordT;

endpackage

`default_nettype wire

// File: source/pipePkg.sv
// --------------------
// Datapath widths and the bundles passed between pipeline stages.
// --------------------
`default_nettype none

package pipePkg;

	import isaPkg::*;

	localparam int dataW = 32;
	localparam int vecW = 256;
	localparam int laneCount = vecW / dataW;
	localparam int regAddrW = regFieldW;
	localparam int regCount = 1 << regAddrW;

	// ALU operation codes.
	localparam logic [2:0] aluAdd = 3'd0;
	localparam logic [2:0] aluSub = 3'd1;
	localparam logic [2:0] aluAnd = 3'd2;
	localparam logic [2:0] aluOrr = 3'd3;

	typedef struct packed {
		logic regWrite;
		logic regWriteV;
		logic memWrite;
		logic vecData;                 // Operands come from the vector file.
		logic [2:0] aluControl;
		logic branch;
		logic aluSrc;
		logic [1:0] flagWrite;         // Bit 1 for NZ, bit 0 for CV.
	} deCtrlT;

	typedef struct packed {
		logic [regAddrW-1:0] ra1;
		logic [regAddrW-1:0] ra2;
		logic [regAddrW-1:0] wa3;
		logic [dataW-1:0] rd1;
		logic [dataW-1:0] rd2;
		logic [vecW-1:0] vrd1;
		logic [vecW-1:0] vrd2;
		logic [dataW-1:0] extImm;
		logic signed [offsetW-1:0] brOffset;
	} deDataT;

	typedef struct packed {
		logic regWrite;
		logic regWriteV;
		logic [regAddrW-1:0] wa3;
		logic [dataW-1:0] result;
		logic [vecW-1:0] vecResult;
	} ewT;

	typedef struct packed {
		logic valid;
		logic [dataW-1:0] addr;
		logic [dataW-1:0] data;
	} memReqT;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flagsT;

endpackage

`default_nettype wire

// File: source/regFile.sv
// --------------------
// Register file, two read ports and one write port.
// Reads of the address being written see the new value.
// --------------------
`default_nettype none

module regFile import pipePkg::*; #(
	parameter int width = dataW
) (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic we,
	input  wire logic [regAddrW-1:0] wa,
	input  wire logic [width-1:0] wd,
	input  wire logic [regAddrW-1:0] ra1,
	input  wire logic [regAddrW-1:0] ra2,
	output logic [width-1:0] rd1,
	output logic [width-1:0] rd2
);

	logic [width-1:0] regs [regCount];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[wa] <= wd;
		end
	end

	// Write-through covers the instruction two behind the writer.
	assign rd1 = (we && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (we && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

// File: source/decodeStage.sv
// --------------------
// Decode stage. Turns the instruction word into controls,
// reads the scalar and vector register files and extends the immediate.
// --------------------
`default_nettype none

module decodeStage import isaPkg::*, pipePkg::*; (
	input  wire logic clk,
	input  wire logic rst,
	input  wire instrWordT instr,
	input  wire logic instrValid,
	input  wire ewT wb,
	input  wire logic wbEn,        // Writeback slot is live this cycle.
	output deCtrlT ctrl,
	output deDataT data
);

	opcodeT opcode;
	logic [dataW-1:0] rd1, rd2;
	logic [vecW-1:0] vrd1, vrd2;

	function automatic logic [2:0] aluFor(input opcodeT op);
		case (op)
			opSub, opVsub: return aluSub;
			opAnd, opVand: return aluAnd;
			opOrr, opVorr: return aluOrr;
			default: return aluAdd;   // Also the store address add.
		endcase
	endfunction

	assign opcode = instr.dp.opcode;

	always_comb begin
		ctrl = '0;                   // Bubble unless valid.
		if (instrValid) begin
			ctrl.aluControl = aluFor(opcode);
			case (opcode)
				opAdd, opSub, opAnd, opOrr: begin
					ctrl.regWrite = 1'b1;
					ctrl.aluSrc = instr.dp.immSel;
					// Logic ops leave C and V alone.
					if (instr.dp.setFlags)
						ctrl.flagWrite = (opcode == opAdd || opcode == opSub) ? 2'b11 : 2'b10;
				end
				opVadd, opVsub, opVand, opVorr: begin
					ctrl.regWriteV = 1'b1;
					ctrl.vecData = 1'b1;
					ctrl.aluSrc = instr.dp.immSel;   // Immediate goes to every lane.
				end
				opStr: begin
					ctrl.memWrite = 1'b1;
					ctrl.aluSrc = 1'b1;
				end
				opB: ctrl.branch = 1'b1;
				default: ;
			endcase
		end
	end

	regFile #(.width(dataW)) scalarRf (
		.clk(clk),
		.rst(rst),
		.we(wbEn & wb.regWrite),
		.wa(wb.wa3),
		.wd(wb.result),
		.ra1(instr.dp.rn),
		.ra2(instr.dp.rm),
		.rd1(rd1),
		.rd2(rd2)
	);

	regFile #(.width(vecW)) vectorRf (
		.clk(clk),
		.rst(rst),
		.we(wbEn & wb.regWriteV),
		.wa(wb.wa3),
		.wd(wb.vecResult),
		.ra1(instr.dp.rn),
		.ra2(instr.dp.rm),
		.rd1(vrd1),
		.rd2(vrd2)
	);

	// Execute picks scalar or vector reads by vecData.
	always_comb begin
		data.ra1 = instr.dp.rn;
		data.ra2 = instr.dp.rm;
		data.wa3 = instr.dp.rd;
		data.rd1 = rd1;
		data.rd2 = rd2;
		data.vrd1 = vrd1;
		data.vrd2 = vrd2;
		data.extImm = dataW'(instr.dp.imm);
		data.brOffset = instr.br.offset;
	end

endmodule

`default_nettype wire

// File: source/regDE.sv
// --------------------
// Decode/Execute pipeline register.
// Holds on stall, loads a bubble on flush.
// --------------------
`default_nettype none

module regDE import pipePkg::*; (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic en,          // Low while stalled.
	input  wire logic clr,         // Flush, wins over stall.
	input  wire deCtrlT ctrlD,
	input  wire deDataT dataD,
	output deCtrlT ctrlE,
	output deDataT dataE
);

	always_ff @(posedge clk) begin
		if (rst || clr) begin
			ctrlE <= '0;
			dataE <= '0;
		end else if (en) begin
			ctrlE <= ctrlD;
			dataE <= dataD;
		end
	end

endmodule

`default_nettype wire

// File: source/forwardUnit.sv
// --------------------
// Forwarding from Writeback into Execute.
// --------------------
`default_nettype none

module forwardUnit import pipePkg::*; (
	input  wire logic [regAddrW-1:0] ra1,
	input  wire logic [regAddrW-1:0] ra2,
	input  wire logic vecData,
	input  wire ewT wb,
	output logic fwd1,
	output logic fwd2
);

	logic wbWrites;

	// Only a write to the file that Execute reads counts as a match.
	assign wbWrites = vecData ? wb.regWriteV : wb.regWrite;

	assign fwd1 = wbWrites && (wb.wa3 == ra1);
	assign fwd2 = wbWrites && (wb.wa3 == ra2);

endmodule

`default_nettype wire

// File: source/executeStage.sv
// --------------------
// Execute stage. Scalar ALU, 8-lane vector ALU, NZCV register,
// branch decision and store request.
// --------------------
`default_nettype none

module executeStage import isaPkg::*, pipePkg::*; (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic en,
	input  wire deCtrlT ctrl,
	input  wire deDataT data,
	input  wire ewT wb,
	output ewT ew,
	output memReqT memReq,
	output logic branchTaken,
	output logic signed [offsetW-1:0] branchOffset,
	output flagsT flags
);

	logic fwd1, fwd2;
	logic [dataW-1:0] srcA, regB, srcB, bEff, result;
	logic [dataW:0] sum;
	logic overflow;
	logic [vecW-1:0] vecA, vecRegB, vecB, vecResult;
	flagsT flagsNext;

	// One lane of ALU work. Carry out in the top bit.
	function automatic logic [dataW:0] laneOp(input logic [dataW-1:0] a,
			input logic [dataW-1:0] b, input logic [2:0] op);
		logic [dataW:0] r;
		case (op)
			aluAdd: r = {1'b0, a} + {1'b0, b};
			aluSub: r = {1'b0, a} + {1'b0, ~b} + 1'b1;   // C is not-borrow.
			aluAnd: r = {1'b0, a & b};
			aluOrr: r = {1'b0, a | b};
			default: r = '0;
		endcase
		return r;
	endfunction

	forwardUnit fwdUnit (
		.ra1(data.ra1),
		.ra2(data.ra2),
		.vecData(ctrl.vecData),
		.wb(wb),
		.fwd1(fwd1),
		.fwd2(fwd2)
	);

	assign srcA = fwd1 ? wb.result : data.rd1;
	assign regB = fwd2 ? wb.result : data.rd2;
	assign srcB = ctrl.aluSrc ? data.extImm : regB;
	assign vecA = fwd1 ? wb.vecResult : data.vrd1;
	assign vecRegB = fwd2 ? wb.vecResult : data.vrd2;
	assign vecB = ctrl.aluSrc ? {laneCount{data.extImm}} : vecRegB;

	assign sum = laneOp(srcA, srcB, ctrl.aluControl);
	assign result = sum[dataW-1:0];

	// Signed overflow on the operand actually added.
	assign bEff = (ctrl.aluControl == aluSub) ? ~srcB : srcB;
	assign overflow = (srcA[dataW-1] == bEff[dataW-1]) && (result[dataW-1] != srcA[dataW-1]);

	// Lanes are independent. No carry crosses a lane boundary.
	always_comb begin
		logic [dataW:0] laneRes;
		for (int i = 0; i < laneCount; i++) begin
			laneRes = laneOp(vecA[i*dataW +: dataW], vecB[i*dataW +: dataW], ctrl.aluControl);
			vecResult[i*dataW +: dataW] = laneRes[dataW-1:0];
		end
	end

	always_comb begin
		flagsNext = flags;
		if (ctrl.flagWrite[1]) begin
			flagsNext.n = result[dataW-1];
			flagsNext.z = (result == '0);
		end
		if (ctrl.flagWrite[0]) begin
			flagsNext.c = sum[dataW];
			flagsNext.v = overflow;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			flags <= '0;
		else if (en)
			flags <= flagsNext;
	end

	// Stalled cycles report nothing. The last free cycle reports once.
	assign branchTaken = ctrl.branch & flags.z & en;
	assign branchOffset = data.brOffset;

	assign memReq.valid = ctrl.memWrite & en;
	assign memReq.addr = result;   // rn + extImm.
	assign memReq.data = regB;

	always_comb begin
		ew.regWrite = ctrl.regWrite;
		ew.regWriteV = ctrl.regWriteV;
		ew.wa3 = data.wa3;
		ew.result = result;
		ew.vecResult = vecResult;
	end

endmodule

`default_nettype wire

// File: source/regEW.sv
// --------------------
// Execute/Writeback pipeline register.
// --------------------
`default_nettype none

module regEW import pipePkg::*; (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic en,
	input  wire ewT ewE,
	output ewT ewW,
	output logic valid
);

	always_ff @(posedge clk) begin
		if (rst)
			ewW <= '0;
		else if (en)
			ewW <= ewE;
	end

	// Entry targets one of the register files.
	assign valid = ewW.regWrite | ewW.regWriteV;

endmodule

`default_nettype wire

// File: source/vecCoreSlice.sv
// --------------------
// Decode to writeback slice of the vector core.
// --------------------
`default_nettype none

module vecCoreSlice import isaPkg::*, pipePkg::*; (
	input  wire logic clk,
	input  wire logic rst,
	input  wire instrWordT instr,
	input  wire logic instrValid,
	input  wire logic stall,       // Level, freezes the slice.
	input  wire logic flush,       // Pulse, kills the instruction in Decode.
	output ewT wb,
	output logic wbValid,
	output memReqT memReq,
	output logic branchTaken,
	output logic signed [offsetW-1:0] branchOffset,
	output flagsT flags
);

	logic en;
	logic ewValid;
	deCtrlT ctrlD, ctrlE;
	deDataT dataD, dataE;
	ewT ewE;

	assign en = ~stall;
	assign wbValid = ewValid & en;   // Also the register file write enable.

	decodeStage decode (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.instrValid(instrValid),
		.wb(wb),
		.wbEn(wbValid),
		.ctrl(ctrlD),
		.data(dataD)
	);

	regDE pipeDE (
		.clk(clk),
		.rst(rst),
		.en(en),
		.clr(flush),
		.ctrlD(ctrlD),
		.dataD(dataD),
		.ctrlE(ctrlE),
		.dataE(dataE)
	);

	executeStage execute (
		.clk(clk),
		.rst(rst),
		.en(en),
		.ctrl(ctrlE),
		.data(dataE),
		.wb(wb),
		.ew(ewE),
		.memReq(memReq),
		.branchTaken(branchTaken),
		.branchOffset(branchOffset),
		.flags(flags)
	);

	regEW pipeEW (
		.clk(clk),
		.rst(rst),
		.en(en),
		.ewE(ewE),
		.ewW(wb),
		.valid(ewValid)
	);

endmodule

`default_nettype wire

// File: tb/tbVecCoreSlice.sv
// --------------------
// Testbench for the vector core slice. Random instructions with
// stalls and flushes, checked against an in-order reference model.
// --------------------
`default_nettype none

module tbVecCoreSlice import isaPkg::*, pipePkg::*; ();

	localparam int instrCount = 400;
	localparam int maxStall = 3;
	localparam int stallBudget = instrCount * maxStall;

	typedef logic signed [offsetW-1:0] offsetT;

	// Expected writeback plus the flags that must be visible with it.
	typedef struct packed {
		ewT ew;
		flagsT flags;
	} wbExpT;

	logic clk;
	logic rst;
	instrWordT instr;
	logic instrValid;
	logic stall;
	logic flush;
	ewT wb;
	logic wbValid;
	memReqT memReq;
	logic branchTaken;
	offsetT branchOffset;
	flagsT flags;

	// Reference state.
	logic [dataW-1:0] sRegs [regCount];
	logic [vecW-1:0] vRegs [regCount];
	flagsT refFlags;
	wbExpT wbQ [$];
	memReqT memQ [$];
	offsetT brQ [$];
	int wbSeen, memSeen, brSeen;

	vecCoreSlice u_vecCoreSlice (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.instrValid(instrValid),
		.stall(stall),
		.flush(flush),
		.wb(wb),
		.wbValid(wbValid),
		.memReq(memReq),
		.branchTaken(branchTaken),
		.branchOffset(branchOffset),
		.flags(flags)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped after a failure");
	endtask

	task automatic reportMismatch(input string sig, input logic [vecW-1:0] got,
			input logic [vecW-1:0] exp);
		$display("[ERROR] %0t %s got %0h expected %0h", $time, sig, got, exp);
		failRun("Value mismatch");
	endtask

	// Operand-dependent fields are only compared for the file that is written.
	task automatic checkEw(input ewT got, input ewT exp);
		if (got.regWrite != exp.regWrite)
			reportMismatch("wb.regWrite", vecW'(got.regWrite), vecW'(exp.regWrite));
		else if (got.regWriteV != exp.regWriteV)
			reportMismatch("wb.regWriteV", vecW'(got.regWriteV), vecW'(exp.regWriteV));
		else if (got.wa3 != exp.wa3)
			reportMismatch("wb.wa3", vecW'(got.wa3), vecW'(exp.wa3));
		else if (exp.regWrite && got.result != exp.result)
			reportMismatch("wb.result", vecW'(got.result), vecW'(exp.result));
		else if (exp.regWriteV && got.vecResult != exp.vecResult)
			reportMismatch("wb.vecResult", got.vecResult, exp.vecResult);
	endtask

	task automatic checkMemReq(input memReqT got, input memReqT exp);
		if (got.addr != exp.addr)
			reportMismatch("memReq.addr", vecW'(got.addr), vecW'(exp.addr));
		else if (got.data != exp.data)
			reportMismatch("memReq.data", vecW'(got.data), vecW'(exp.data));
	endtask

	task automatic checkFlags(input flagsT got, input flagsT exp);
		if (got != exp)
			reportMismatch("flags", vecW'(got), vecW'(exp));
	endtask

	task automatic checkBranch(input offsetT got, input offsetT exp);
		if (got != exp)
			reportMismatch("branchOffset", vecW'(got), vecW'(exp));
	endtask

	// One 32-bit ALU operation for scalar ops and for each vector lane.
	function automatic logic [dataW-1:0] aluRef(input opcodeT op, input logic [dataW-1:0] a,
			input logic [dataW-1:0] b);
		case (op)
			opSub, opVsub: return a - b;
			opAnd, opVand: return a & b;
			opOrr, opVorr: return a | b;
			default: return a + b;
		endcase
	endfunction

	// NZ always. CV only for add and subtract.
	function automatic flagsT flagsRef(input flagsT old, input opcodeT op,
			input logic [dataW-1:0] a, input logic [dataW-1:0] b, input logic [dataW-1:0] r);
		flagsT f;
		logic [dataW:0] wide;
		f = old;
		f.n = r[dataW-1];
		f.z = (r == '0);
		if (op == opAdd) begin
			wide = {1'b0, a} + {1'b0, b};
			f.c = wide[dataW];
			f.v = (a[dataW-1] == b[dataW-1]) && (r[dataW-1] != a[dataW-1]);
		end else if (op == opSub) begin
			f.c = (a >= b);                   // No borrow.
			f.v = (a[dataW-1] != b[dataW-1]) && (r[dataW-1] != a[dataW-1]);
		end
		return f;
	endfunction

	// Applies one accepted instruction to the model and queues its results.
	task automatic applyRef(input instrWordT w);
		dpFormT d;
		wbExpT e;
		logic [dataW-1:0] a, b;
		d = w.dp;
		a = sRegs[d.rn];
		b = d.immSel ? dataW'(d.imm) : sRegs[d.rm];
		e = '0;
		case (d.opcode)
			opAdd, opSub, opAnd, opOrr: begin
				e.ew.regWrite = 1'b1;
				e.ew.wa3 = d.rd;
				e.ew.result = aluRef(d.opcode, a, b);
				if (d.setFlags)
					refFlags = flagsRef(refFlags, d.opcode, a, b, e.ew.result);
				sRegs[d.rd] = e.ew.result;
				e.flags = refFlags;
				wbQ.push_back(e);
			end
			opVadd, opVsub, opVand, opVorr: begin
				e.ew.regWriteV = 1'b1;
				e.ew.wa3 = d.rd;
				// The immediate, when selected, is the second operand of every lane.
				for (int i = 0; i < laneCount; i++)
					e.ew.vecResult[i*dataW +: dataW] = aluRef(d.opcode,
						vRegs[d.rn][i*dataW +: dataW],
						d.immSel ? dataW'(d.imm) : vRegs[d.rm][i*dataW +: dataW]);
				vRegs[d.rd] = e.ew.vecResult;
				e.flags = refFlags;
				wbQ.push_back(e);
			end
			opStr: memQ.push_back({1'b1, sRegs[d.rn] + dataW'(d.imm), sRegs[d.rm]});
			opB: if (refFlags.z) brQ.push_back(w.br.offset);
			default: ;
		endcase
	endtask

	// Few registers so that neighbours often depend on each other.
	function automatic instrWordT randInstr();
		instrWordT w;
		w.dp.opcode = opcodeT'(4'($urandom_range(10, 0)));
		w.dp.immSel = 1'($urandom);
		w.dp.setFlags = 1'($urandom);
		w.dp.rd = regAddrW'($urandom_range(3, 0));
		w.dp.rn = regAddrW'($urandom_range(3, 0));
		w.dp.rm = regAddrW'($urandom_range(3, 0));
		w.dp.imm = ($urandom_range(3, 0) == 0) ? '0 : immW'($urandom);
		if (w.dp.opcode == opB)
			w.br.offset = offsetW'($urandom);
		return w;
	endfunction

	initial begin : stimulus
		instrWordT w;
		logic v;
		int stallLen;
		void'($urandom(32'h97a1_8c5f));
		rst = 1'b1;
		instr = '0;
		instrValid = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		for (int i = 0; i < regCount; i++) begin
			sRegs[i] = '0;
			vRegs[i] = '0;
		end
		refFlags = '0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int n = 0; n < instrCount; n++) begin
			w = randInstr();
			v = ($urandom_range(7, 0) != 0);
			instr = w;
			instrValid = v;
			flush = 1'b0;
			if ($urandom_range(5, 0) == 0) begin
				stallLen = $urandom_range(maxStall, 1);
				stall = 1'b1;                  // Instruction held meanwhile.
				repeat (stallLen) begin
					@(posedge clk);
					#1;
				end
				stall = 1'b0;
			end
			flush = ($urandom_range(9, 0) == 0);   // Never together with stall.
			if (v && !flush)
				applyRef(w);
			@(posedge clk);
			#1;
		end
		instrValid = 1'b0;
		flush = 1'b0;
		repeat (8) begin
			@(posedge clk);
			#1;
		end
		if (wbQ.size() != 0 || memQ.size() != 0 || brQ.size() != 0) begin
			failRun($sformatf("Missing results: %0d writebacks, %0d stores, %0d branches",
				wbQ.size(), memQ.size(), brQ.size()));
		end else begin
			checkFlags(flags, refFlags);
			$display("Checked %0d writebacks, %0d stores, %0d branches", wbSeen, memSeen, brSeen);
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

	// Outputs are sampled at the falling edge, well away from input changes.
	initial begin : compare
		wbExpT e;
		wbSeen = 0;
		memSeen = 0;
		brSeen = 0;
		@(negedge clk);
		while (rst !== 1'b0)
			@(negedge clk);
		if (wbValid || memReq.valid || branchTaken || flags != '0)
			failRun("Outputs were not cleared by reset");
		forever begin
			if (wbValid) begin
				if (wbQ.size() == 0) begin
					failRun($sformatf("Unexpected writeback at time %0t", $time));
				end else begin
					e = wbQ.pop_front();
					checkEw(wb, e.ew);
					checkFlags(flags, e.flags);
					wbSeen++;
				end
			end
			if (memReq.valid) begin
				if (memQ.size() == 0) begin
					failRun($sformatf("Unexpected store request at time %0t", $time));
				end else begin
					checkMemReq(memReq, memQ.pop_front());
					memSeen++;
				end
			end
			if (branchTaken) begin
				if (brQ.size() == 0) begin
					failRun($sformatf("Unexpected taken branch at time %0t", $time));
				end else begin
					checkBranch(branchOffset, brQ.pop_front());
					brSeen++;
				end
			end
			@(negedge clk);
		end
	end

	initial begin : watchdog
		#((instrCount + stallBudget + 50) * 10);
		failRun("Timeout, the run did not reach its end in time");
	end

endmodule

`default_nettype wire

// File: verilog.f
source/isaPkg.sv
source/pipePkg.sv
source/regFile.sv
source/decodeStage.sv
source/regDE.sv
source/forwardUnit.sv
source/executeStage.sv
source/regEW.sv
source/vecCoreSlice.sv
tb/tbVecCoreSlice.sv

// File: run.sh
#!/bin/sh
# Build the slice and its testbench with Verilator, run it, look for the pass line.
verilator --binary --timing -f verilog.f --top-module tbVecCoreSlice -o simv \
	|| { echo "Build failed"; exit 1; }
out=$(./obj_dir/simv)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1
